// File: Bender.yml
package:
  name: cpu16

sources:
  - files:
      - cpu_pkg.sv
      - pipe_if.sv
      - fetch_stage.sv
      - decode_stage.sv
      - execute_stage.sv
      - memory_stage.sv
      - cpu_top.sv
  - target: simulation
    files:
      - tb_cpu.sv

// File: cpu_pkg.sv
package cpu_pkg;

   // Data, address and instruction words are all one 16-bit word
   typedef logic [15:0] word_t;

   // Eight general registers, r0 included
   typedef logic [2:0] reg_idx_t;

   // Opcodes in bits 15..12
   typedef enum logic [3:0] {
      NOP  = 4'h0,
      ADD  = 4'h1,
      SUB  = 4'h2,
      AND  = 4'h3,
      OR   = 4'h4,
      XOR  = 4'h5,
      ADDI = 4'h6,
      LI   = 4'h7,
      LD   = 4'h8,
      ST   = 4'h9,
      BEQZ = 4'ha,
      BNEZ = 4'hb,
      J    = 4'hc,
      HALT = 4'hd
   } op_e;

   // Instruction field positions
   localparam int op_msb    = 15;
   localparam int op_lsb    = 12;
   localparam int rd_msb    = 11;
   localparam int rd_lsb    = 9;
   localparam int rs_msb    = 8;
   localparam int rs_lsb    = 6;
   localparam int rt_msb    = 5;
   localparam int rt_lsb    = 3;
   localparam int imm6_msb  = 5;
   localparam int imm9_msb  = 8;
   localparam int off12_msb = 11;

   // Bubble inserted on stall or flush
   localparam word_t nop_instr = '0;

   // Keep bits msb..0, copy bit msb upward
   function automatic word_t sign_ext(word_t raw, int msb);
      word_t res;
      for (int i = 0; i < 16; i++) begin
         res[i] = (i <= msb) ? raw[i] : raw[msb];
      end
      return res;
   endfunction

   // ALU, also used for LD/ST address generation
   function automatic word_t alu_calc(op_e op, word_t a, word_t b, word_t imm);
      word_t res;
      case (op)
         ADD:          res = a + b;
         SUB:          res = a - b;
         AND:          res = a & b;
         OR:           res = a | b;
         XOR:          res = a ^ b;
         ADDI, LD, ST: res = a + imm;
         LI:           res = imm;
         default:      res = '0;
      endcase
      return res;
   endfunction

endpackage

// File: cpu_tests.txt
# Records: P word | M addr data | W reg data | S addr data | E ends a test
# Values in hex; a line may hold several records; W and S listed in trace order
# ALU and immediates back to back, each result used at once
P 7205 P 6443 P 1650 P 28c8 P 3b18 P 4d48 P 5f90 P 61fe
P 73ff P 2408 P d000
W 1 0005 W 2 0008 W 3 000d W 4 0008 W 5 0008 W 6 000d
W 7 0005 W 0 0003 W 1 ffff W 2 0004
E
# Loads and stores under random wait states, negative offset store
P 7220 P 8440 P 8641 P 9444 P 9645 P 8844 P 927f P d000
M 0020 1234 M 0021 00ff
W 1 0020 W 2 1234 W 3 00ff W 4 1234
S 0024 1234 S 0025 00ff S 001f 0020
E
# Load-use on ALU source, store data and ADDI source
P 7210 P 8440 P 1690 P 8841 P 9842 P 8a40 P 6d41 P d000
M 0010 0007 M 0011 fff0
W 1 0010 W 2 0007 W 3 000e W 4 fff0 W 5 0007 W 6 0008
S 0012 fff0
E
# BEQZ and BNEZ taken and not taken, then J over two words
P 7200 P 7403 P a202 P 7611 P 7612 P b201 P 7821 P a401
P b401 P 7a31 P c002 P 7c41 P 7c42 P 6e81 P d000
W 1 0000 W 2 0003 W 4 0021 W 7 0004
E
# Nothing after HALT may retire or touch the bus
P 7209 P d000 P 7401 P 9240 P 7602
W 1 0009
E
# First program again after reset, registers carry older values
P 7205 P 6443 P 1650 P 28c8 P 3b18 P 4d48 P 5f90 P 61fe
P 73ff P 2408 P d000
W 1 0005 W 2 0008 W 3 000d W 4 0008 W 5 0008 W 6 000d
W 7 0005 W 0 0003 W 1 ffff W 2 0004
E

// File: cpu_top.sv
`timescale 1ns/1ns

module cpu_top
   import cpu_pkg::*;
#(
   parameter int IMEM_DEPTH = 256
) (
   input  logic     clk,
   input  logic     rst_n,
   // Program load
   input  logic     imem_we,
   input  word_t    imem_addr,
   input  word_t    imem_wdata,
   // Wishbone data bus
   output logic     cyc,
   output logic     stb,
   output logic     we,
   output word_t    adr,
   output word_t    dat_w,
   input  word_t    dat_r,
   input  logic     ack,
   // Retirement trace
   output logic     wb_we,
   output reg_idx_t wb_rd,
   output word_t    wb_data,
   output logic     halted
);

   logic  if_valid;
   word_t if_instr;
   word_t if_pc_inc;
   logic  stall;
   logic  redirect;
   word_t redirect_pc;
   logic  mem_busy;

   id_ex_if  id_ex_bus ();
   ex_mem_if ex_mem_bus ();

   fetch_stage #(
      .IMEM_DEPTH (IMEM_DEPTH)
   ) fetch_stage_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .imem_we     (imem_we),
      .imem_addr   (imem_addr),
      .imem_wdata  (imem_wdata),
      .stall       (stall),
      .mem_busy    (mem_busy),
      .halted      (halted),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .if_valid    (if_valid),
      .if_instr    (if_instr),
      .if_pc_inc   (if_pc_inc)
   );

   decode_stage decode_stage_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .if_valid  (if_valid),
      .if_instr  (if_instr),
      .if_pc_inc (if_pc_inc),
      .redirect  (redirect),
      .mem_busy  (mem_busy),
      .wb_we     (wb_we),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data),
      .ex_fwd    (ex_mem_bus),
      .id_ex     (id_ex_bus),
      .stall     (stall)
   );

   execute_stage execute_stage_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .mem_busy    (mem_busy),
      .id_ex       (id_ex_bus),
      .ex_mem      (ex_mem_bus),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   // Also performs writeback
   memory_stage memory_stage_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .dat_r    (dat_r),
      .ack      (ack),
      .ex_mem   (ex_mem_bus),
      .cyc      (cyc),
      .stb      (stb),
      .we       (we),
      .adr      (adr),
      .dat_w    (dat_w),
      .mem_busy (mem_busy),
      .wb_we    (wb_we),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data),
      .halted   (halted)
   );

endmodule

// File: decode_stage.sv
`timescale 1ns/1ns

module decode_stage
   import cpu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      if_valid,
   input  word_t     if_instr,
   input  word_t     if_pc_inc,
   input  logic      redirect,
   input  logic      mem_busy,
   // Writeback from the memory stage
   input  logic      wb_we,
   input  reg_idx_t  wb_rd,
   input  word_t     wb_data,
   ex_mem_if.monitor ex_fwd,
   id_ex_if.source   id_ex,
   output logic      stall
);

   word_t    regs [8];
   op_e      op_raw;
   op_e      op_d;
   word_t    instr_d;
   reg_idx_t rd_idx;
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   reg_idx_t srcb_idx;
   logic     is_rtype;
   logic     uses_a;
   logic     uses_b;
   logic     writes_rd;
   logic     bubble;
   word_t    imm_d;
   word_t    ex_result;
   word_t    opa_fwd;
   word_t    opb_fwd;

   // Operand source with forwarding, youngest producer first
   function automatic word_t fwd(input reg_idx_t idx);
      // Instruction now in execute, loads excluded (they stall)
      if (id_ex.valid && id_ex.rd_we && id_ex.op != LD && id_ex.rd == idx) begin
         return ex_result;
      end
      // Memory stage, non-load result already known
      if (ex_fwd.valid && ex_fwd.rd_we && ex_fwd.op != LD && ex_fwd.rd == idx) begin
         return ex_fwd.result;
      end
      // Writeback this cycle, covers load data on ack
      if (wb_we && wb_rd == idx) begin
         return wb_data;
      end
      return regs[idx];
   endfunction

   // Raw fields
   assign op_raw = op_e'(if_instr[op_msb:op_lsb]);
   assign rd_idx = if_instr[rd_msb:rd_lsb];
   assign rs_idx = if_instr[rs_msb:rs_lsb];
   assign rt_idx = if_instr[rt_msb:rt_lsb];

   always_comb begin
      is_rtype  = op_raw inside {ADD, SUB, AND, OR, XOR};
      uses_a    = is_rtype || (op_raw inside {ADDI, LD, ST});
      // ST stores rd, branches test rd
      uses_b    = is_rtype || (op_raw inside {ST, BEQZ, BNEZ});
      writes_rd = is_rtype || (op_raw inside {ADDI, LI, LD});
      srcb_idx  = is_rtype ? rt_idx : rd_idx;
      case (op_raw)
         LI:      imm_d = sign_ext(if_instr, imm9_msb);
         J:       imm_d = sign_ext(if_instr, off12_msb);
         default: imm_d = sign_ext(if_instr, imm6_msb);
      endcase
   end

   // Same result execute will produce at the next edge
   assign ex_result = alu_calc(id_ex.op, id_ex.opa, id_ex.opb, id_ex.imm);

   // Load in execute feeding this instruction
   assign stall = if_valid && id_ex.valid && id_ex.op == LD &&
                  ((uses_a && rs_idx == id_ex.rd) || (uses_b && srcb_idx == id_ex.rd));

   assign bubble  = stall || redirect || !if_valid;
   assign instr_d = bubble ? nop_instr : if_instr;
   assign op_d    = op_e'(instr_d[op_msb:op_lsb]);

   always_comb begin
      opa_fwd = fwd(rs_idx);
      opb_fwd = fwd(srcb_idx);
   end

   // Register file
   always_ff @(posedge clk) begin
      if (wb_we) begin
         regs[wb_rd] <= wb_data;
      end
   end

   // ID/EX control
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex.valid <= 1'b0;
         id_ex.op    <= NOP;
         id_ex.rd_we <= 1'b0;
      end else if (!mem_busy) begin
         id_ex.valid <= !bubble;
         id_ex.op    <= op_d;
         id_ex.rd_we <= writes_rd && !bubble;
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      if (!mem_busy) begin
         id_ex.rd     <= rd_idx;
         id_ex.opa    <= opa_fwd;
         id_ex.opb    <= opb_fwd;
         id_ex.imm    <= imm_d;
         id_ex.pc_inc <= if_pc_inc;
      end
   end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ns

module execute_stage
   import cpu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      mem_busy,
   id_ex_if.sink     id_ex,
   ex_mem_if.source  ex_mem,
   output logic      redirect,
   output word_t     redirect_pc
);

   logic  taken;
   word_t alu_out;

   // Branch condition on rd value, carried in opb
   always_comb begin
      case (id_ex.op)
         BEQZ:    taken = (id_ex.opb == '0);
         BNEZ:    taken = (id_ex.opb != '0);
         J:       taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign redirect = id_ex.valid && taken;

   // Target relative to PC + 1, imm already sized by decode
   assign redirect_pc = id_ex.pc_inc + id_ex.imm;

   assign alu_out = alu_calc(id_ex.op, id_ex.opa, id_ex.opb, id_ex.imm);

   // EX/MEM control
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_mem.valid <= 1'b0;
         ex_mem.op    <= NOP;
         ex_mem.rd_we <= 1'b0;
      end else if (!mem_busy) begin
         // Taken branch or jump goes on as a bubble
         ex_mem.valid <= id_ex.valid && !redirect;
         ex_mem.op    <= redirect ? NOP : id_ex.op;
         ex_mem.rd_we <= id_ex.rd_we && !redirect;
      end
   end

   // EX/MEM payload
   always_ff @(posedge clk) begin
      if (!mem_busy) begin
         ex_mem.rd         <= id_ex.rd;
         ex_mem.result     <= alu_out;
         // Value of rd for ST
         ex_mem.store_data <= id_ex.opb;
      end
   end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
   import cpu_pkg::*;
#(
   parameter int IMEM_DEPTH = 256
) (
   input  logic  clk,
   input  logic  rst_n,
   // Program load port, used while in reset
   input  logic  imem_we,
   input  word_t imem_addr,
   input  word_t imem_wdata,
   input  logic  stall,
   input  logic  mem_busy,
   input  logic  halted,
   input  logic  redirect,
   input  word_t redirect_pc,
   output logic  if_valid,
   output word_t if_instr,
   output word_t if_pc_inc
);

   localparam int aw = $clog2(IMEM_DEPTH);

   word_t imem [IMEM_DEPTH];
   word_t pc;
   word_t pc_seq;
   logic  advance;

   assign pc_seq = pc + 16'd1;

   // Whole front end freezes on bus wait or after halt
   assign advance = !mem_busy && !halted;

   // Instruction memory write port
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr[aw-1:0]] <= imem_wdata;
      end
   end

   // PC and IF/ID valid
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc       <= '0;
         if_valid <= 1'b0;
      end else if (advance) begin
         if (redirect) begin
            // Squash the instruction being fetched
            pc       <= redirect_pc;
            if_valid <= 1'b0;
         end else if (!stall) begin
            pc       <= pc_seq;
            if_valid <= 1'b1;
         end
      end
   end

   // IF/ID payload, held on load-use stall
   always_ff @(posedge clk) begin
      if (advance && !redirect && !stall) begin
         if_instr  <= imem[pc[aw-1:0]];
         if_pc_inc <= pc_seq;
      end
   end

endmodule

// File: memory_stage.sv
`timescale 1ns/1ns

module memory_stage
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   // Wishbone classic master
   input  word_t    dat_r,
   input  logic     ack,
   ex_mem_if.sink   ex_mem,
   output logic     cyc,
   output logic     stb,
   output logic     we,
   output word_t    adr,
   output word_t    dat_w,
   output logic     mem_busy,
   // Writeback and trace
   output logic     wb_we,
   output reg_idx_t wb_rd,
   output word_t    wb_data,
   output logic     halted
);

   logic is_mem;
   logic is_ld;
   logic bus_done;
   logic halt_q;

   assign is_mem   = ex_mem.valid && (ex_mem.op inside {LD, ST});
   assign is_ld    = ex_mem.op == LD;
   assign bus_done = cyc && ack;

   // High from the cycle HALT arrives, sticky until reset
   assign halted = halt_q || (ex_mem.valid && ex_mem.op == HALT);

   // Holds every pipeline register until ack
   assign mem_busy = is_mem && !halted && !bus_done;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halt_q <= 1'b0;
      end else begin
         halt_q <= halted;
      end
   end

   // Cycle opens one clock after the op arrives, closes after ack
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cyc <= 1'b0;
      end else if (bus_done) begin
         cyc <= 1'b0;
      end else if (is_mem && !halted) begin
         cyc <= 1'b1;
      end
   end

   // Address and data stay put, EX/MEM is frozen while busy
   assign stb   = cyc;
   assign we    = ex_mem.op == ST;
   assign adr   = ex_mem.result;
   assign dat_w = ex_mem.store_data;

   // Load data written back in the ack cycle
   assign wb_we   = ex_mem.valid && ex_mem.rd_we && !halted && (!is_ld || bus_done);
   assign wb_rd   = ex_mem.rd;
   assign wb_data = is_ld ? dat_r : ex_mem.result;

endmodule

// File: pipe_if.sv
`timescale 1ns/1ns

// Decode to execute pipeline register contents
interface id_ex_if
   import cpu_pkg::*;
();
   logic     valid;
   op_e      op;
   reg_idx_t rd;
   logic     rd_we;
   // Operands after forwarding
   word_t    opa;
   word_t    opb;
   word_t    imm;
   word_t    pc_inc;

   modport source (output valid, op, rd, rd_we, opa, opb, imm, pc_inc);
   modport sink   (input  valid, op, rd, rd_we, opa, opb, imm, pc_inc);
endinterface

// Execute to memory pipeline register contents
interface ex_mem_if
   import cpu_pkg::*;
();
   logic     valid;
   op_e      op;
   reg_idx_t rd;
   logic     rd_we;
   // ALU result, or address for LD/ST
   word_t    result;
   word_t    store_data;

   modport source  (output valid, op, rd, rd_we, result, store_data);
   modport sink    (input  valid, op, rd, rd_we, result, store_data);
   // Decode peeks here for forwarding
   modport monitor (input  valid, op, rd, rd_we, result);
endinterface

// File: tb.f
cpu_pkg.sv
pipe_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// File: tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;
   import cpu_pkg::*;

   localparam string tests_file = "cpu_tests.txt";
   localparam int post_halt_cycles = 20;

   logic     clk;
   logic     rst_n;
   logic     imem_we;
   word_t    imem_addr;
   word_t    imem_wdata;
   logic     cyc;
   logic     stb;
   logic     we;
   word_t    adr;
   word_t    dat_w;
   word_t    dat_r;
   logic     ack;
   logic     wb_we;
   reg_idx_t wb_rd;
   word_t    wb_data;
   logic     halted;

   // Parsed records of the whole test file in file order
   byte      rec_kind [$];
   word_t    rec_a [$];
   word_t    rec_b [$];
   // Trace still expected from the running test
   reg_idx_t exp_rd [$];
   word_t    exp_wb [$];
   word_t    exp_adr [$];
   word_t    exp_dat [$];
   // Sparse data memory model
   word_t    dmem [word_t];
   int       wait_left;
   int       cycles;
   int       cycle_limit;
   int       rec_idx;

   cpu_top #(
      .IMEM_DEPTH (256)
   ) cpu_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .wb_we      (wb_we),
      .wb_rd      (wb_rd),
      .wb_data    (wb_data),
      .halted     (halted)
   );

   always #2 clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_wb(input reg_idx_t rd, input word_t data);
      if (wb_rd !== rd) begin
         stop_on_error($sformatf("ERROR wb_rd expected %h actual %h", rd, wb_rd));
      end else if (wb_data !== data) begin
         stop_on_error($sformatf("ERROR wb_data expected %h actual %h", data, wb_data));
      end
   endtask

   task automatic check_store(input word_t addr, input word_t data);
      if (adr !== addr) begin
         stop_on_error($sformatf("ERROR adr expected %h actual %h", addr, adr));
      end else if (dat_w !== data) begin
         stop_on_error($sformatf("ERROR dat_w expected %h actual %h", data, dat_w));
      end
   endtask

   // Unwritten words read back as their own address scrambled
   function automatic word_t read_word(input word_t a);
      return dmem.exists(a) ? dmem[a] : (a ^ 16'h5a5a);
   endfunction

   // Global cycle budget
   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         stop_on_error($sformatf("Timeout, run went past %0d cycles", cycle_limit));
      end
   end

   // Wishbone slave with 0 to 3 random wait cycles
   always @(posedge clk) begin
      if (!rst_n) begin
         ack <= 1'b0;
         wait_left = -1;
      end else if (ack) begin
         ack <= 1'b0;
         wait_left = -1;
      end else if (cyc && stb) begin
         if (wait_left < 0) begin
            wait_left = $urandom % 4;
         end
         if (wait_left == 0) begin
            ack <= 1'b1;
            if (we) begin
               dmem[adr] = dat_w;
            end else begin
               dat_r <= read_word(adr);
            end
            wait_left = -1;
         end else begin
            wait_left--;
         end
      end
   end

   // Trace and store monitor on pre-edge values
   always @(posedge clk) begin
      if (rst_n && wb_we) begin
         if (exp_rd.size() == 0) begin
            stop_on_error("Writeback seen beyond the expected ones");
         end else begin
            check_wb(exp_rd.pop_front(), exp_wb.pop_front());
         end
      end
      if (rst_n && cyc && stb && we && ack) begin
         if (exp_adr.size() == 0) begin
            stop_on_error("Store seen beyond the expected ones");
         end else begin
            check_store(exp_adr.pop_front(), exp_dat.pop_front());
         end
      end
   end

   task automatic parse_tests();
      int fd;
      int n_events;
      int n_tests;
      logic [8*16-1:0]  tok;
      logic [8*128-1:0] rest;
      word_t a;
      word_t b;
      n_events = 0;
      n_tests  = 0;
      fd = $fopen(tests_file, "r");
      if (fd == 0) begin
         stop_on_error("Cannot open the test file cpu_tests.txt");
      end else begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            a = '0;
            b = '0;
            if (tok == "#") begin
               // Skip comment to end of line
               void'($fgets(rest, fd));
            end else if (tok == "P" || tok == "E") begin
               if (tok == "P") begin
                  void'($fscanf(fd, "%h", a));
                  n_events++;
               end else begin
                  n_tests++;
               end
               rec_kind.push_back(tok[7:0]);
               rec_a.push_back(a);
               rec_b.push_back(b);
            end else if (tok == "M" || tok == "W" || tok == "S") begin
               void'($fscanf(fd, "%h %h", a, b));
               if (tok != "M") begin
                  n_events++;
               end
               rec_kind.push_back(tok[7:0]);
               rec_a.push_back(a);
               rec_b.push_back(b);
            end else begin
               stop_on_error("Unknown record kind in cpu_tests.txt");
            end
         end
         $fclose(fd);
         cycle_limit = 10 * n_events + 50 * n_tests;
      end
   endtask

   // One test block from its first record through E
   task automatic run_test(inout int idx);
      int pc;
      pc = 0;
      exp_rd.delete();
      exp_wb.delete();
      exp_adr.delete();
      exp_dat.delete();
      dmem.delete();
      @(posedge clk);
      rst_n <= 1'b0;
      while (rec_kind[idx] != "E") begin
         case (rec_kind[idx])
            "P": begin
               // One program word per clock into the imem load port
               @(posedge clk);
               imem_we    <= 1'b1;
               imem_addr  <= word_t'(pc);
               imem_wdata <= rec_a[idx];
               pc++;
            end
            "M": dmem[rec_a[idx]] = rec_b[idx];
            "W": begin
               exp_rd.push_back(reg_idx_t'(rec_a[idx]));
               exp_wb.push_back(rec_b[idx]);
            end
            default: begin
               exp_adr.push_back(rec_a[idx]);
               exp_dat.push_back(rec_b[idx]);
            end
         endcase
         idx++;
      end
      idx++;
      @(posedge clk);
      imem_we <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      while (!halted) @(posedge clk);
      // Core must stay frozen after HALT
      repeat (post_halt_cycles) begin
         @(posedge clk);
         if (!halted) begin
            stop_on_error("halted dropped after HALT");
         end else if (cyc || stb || wb_we) begin
            stop_on_error("Bus cycle or writeback after HALT");
         end
      end
      if (exp_rd.size() != 0 || exp_adr.size() != 0) begin
         stop_on_error($sformatf("Missing trace, %0d writebacks and %0d stores never seen",
                                 exp_rd.size(), exp_adr.size()));
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      imem_we     = 1'b0;
      imem_addr   = '0;
      imem_wdata  = '0;
      dat_r       = '0;
      ack         = 1'b0;
      wait_left   = -1;
      cycles      = 0;
      cycle_limit = 0;
      rec_idx     = 0;
      void'($urandom(32'h5f58));
      parse_tests();
      while (rec_idx < rec_kind.size()) begin
         run_test(rec_idx);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule
